// ==== rtl/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

  //////////////////////////////////////////////////
  // Write-back state.
  //////////////////////////////////////////////////

  // Bit 1 set marks a pending memory access.
  typedef enum logic [1:0] {
    st_idle  = 2'b00,
    st_alu   = 2'b01,
    st_store = 2'b10,
    st_load  = 2'b11
  } wb_state_e;

  //////////////////////////////////////////////////
  // Widths and codes.
  //////////////////////////////////////////////////

  localparam int unsigned DATA_W_DFLT = 32;
  localparam int unsigned IDX_W_DFLT  = 5;
  localparam int unsigned NUM_GPR     = 16; // Indexes at or above are not written.

  localparam logic [4:0] LSU_VEC_LOAD  = 5'b00101;
  localparam logic [4:0] LSU_VEC_OTHER = 5'b00111;

endpackage

`default_nettype wire

// ==== rtl/wb_state_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_state_ctrl (
  input  var logic              wb_clk,
  input  var logic              cpurst_b,
  input  var logic              alu_cmplt,
  input  var logic              load_issue,
  input  var logic              store_issue,
  input  var logic              lsu_cmplt,
  output wb_pkg::wb_state_e     state,
  output logic                  ldst_wait,
  output logic                  st_aft_load,
  output logic                  store_uncmplt,
  output logic [4:0]            lsu_vec
);

  wb_pkg::wb_state_e next_state;
  wb_pkg::wb_state_e strobe_state;
  logic              any_strobe;
  logic              in_ldst;

  //////////////////////////////////////////////////
  // State register.
  //////////////////////////////////////////////////

  always_ff @(posedge wb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      state <= wb_pkg::st_idle;
    else
      state <= next_state;
  end

  assign any_strobe = alu_cmplt || load_issue || store_issue;

  // At most one strobe per cycle.
  always_comb
  begin
    if (load_issue)
      strobe_state = wb_pkg::st_load;
    else if (store_issue)
      strobe_state = wb_pkg::st_store;
    else if (alu_cmplt)
      strobe_state = wb_pkg::st_alu;
    else
      strobe_state = wb_pkg::st_idle;
  end

  always_comb
  begin
    case (state)
      wb_pkg::st_idle,
      wb_pkg::st_alu:
        next_state = any_strobe ? strobe_state : wb_pkg::st_idle;
      wb_pkg::st_load,
      wb_pkg::st_store:
      begin
        if (!lsu_cmplt)
          next_state = state; // Access still in flight.
        else if (any_strobe)
          next_state = strobe_state;
        else
          next_state = wb_pkg::st_idle;
      end
      default:
        next_state = wb_pkg::st_idle;
    endcase
  end

  //////////////////////////////////////////////////
  // State decodes.
  //////////////////////////////////////////////////

  assign in_ldst       = (state == wb_pkg::st_load) || (state == wb_pkg::st_store);
  assign ldst_wait     = in_ldst && !lsu_cmplt;
  assign store_uncmplt = (state == wb_pkg::st_store) && !lsu_cmplt;

  // Load leaving write-back, by a store behind it or by going idle.
  assign st_aft_load = (state == wb_pkg::st_load)
                       && (store_issue || (next_state == wb_pkg::st_idle));

  assign lsu_vec = (state == wb_pkg::st_load) ? wb_pkg::LSU_VEC_LOAD
                                              : wb_pkg::LSU_VEC_OTHER;

endmodule

`default_nettype wire

// ==== rtl/wb_result_buf.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_result_buf #(
  parameter int unsigned DATA_W = wb_pkg::DATA_W_DFLT,
  parameter int unsigned IDX_W  = wb_pkg::IDX_W_DFLT
) (
  input  var logic              wb_clk,
  input  var logic              cpurst_b,
  input  wb_pkg::wb_state_e     state,
  input  var logic              alu_cmplt,
  input  var logic              load_issue,
  input  var logic              inst_cmplt,
  input  var logic [DATA_W-1:0] rbus_data,
  input  var logic [IDX_W-1:0]  rbus_dst_idx,
  input  var logic [DATA_W-1:0] lsu_addr,
  input  var logic              lsu_addr_vld,
  input  var logic              lsu_cmplt,
  input  var logic              lsu_data_vld,
  input  var logic [DATA_W-1:0] lsu_load_data,
  input  var logic              ldst_wait,
  input  var logic              st_aft_load,
  output logic [DATA_W-1:0]     wb_data_buf,
  output logic                  reg_we,
  output logic [IDX_W-1:0]      reg_idx,
  output logic [DATA_W-1:0]     reg_data,
  output logic                  fwd_en,
  output logic [DATA_W-1:0]     fwd_data
);

  logic [IDX_W-1:0]  idx_buf;
  logic [DATA_W-1:0] data_nxt;
  logic              data_upd;
  logic              idx_upd;
  logic              dst_vld;
  logic              alu_or_load;

  //////////////////////////////////////////////////
  // Index and data buffers.
  //////////////////////////////////////////////////

  assign idx_upd = alu_cmplt || load_issue;

  always_ff @(posedge wb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      idx_buf <= '0;
    else if (idx_upd)
      idx_buf <= rbus_dst_idx;
  end

  // Address wins over result bus data.
  assign data_nxt = lsu_addr_vld ? lsu_addr : rbus_data;
  assign data_upd = alu_cmplt
                    || inst_cmplt
                    || (lsu_addr_vld && !ldst_wait)
                    || st_aft_load;

  always_ff @(posedge wb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      wb_data_buf <= '0;
    else if (data_upd)
      wb_data_buf <= data_nxt;
  end

  //////////////////////////////////////////////////
  // Register file write and forwarding.
  //////////////////////////////////////////////////

  // Index zero and the unimplemented upper registers are never written.
  assign dst_vld = (idx_buf != '0) && (32'(idx_buf) < wb_pkg::NUM_GPR);

  assign alu_or_load = (state == wb_pkg::st_alu)
                       || ((state == wb_pkg::st_load) && lsu_cmplt && lsu_data_vld);

  assign reg_we   = alu_or_load && dst_vld;
  assign reg_idx  = idx_buf;
  assign reg_data = (state == wb_pkg::st_load) ? lsu_load_data : wb_data_buf;

  assign fwd_en   = ((state == wb_pkg::st_alu) || (state == wb_pkg::st_load)) && dst_vld;
  assign fwd_data = wb_data_buf; // Load data is not forwarded.

endmodule

`default_nettype wire

// ==== rtl/wb_hazard.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_hazard (
  input  wb_pkg::wb_state_e state,
  input  var logic          lsu_cmplt,
  input  var logic          lsu_acc_err,
  input  var logic          lsu_chk_fail,
  input  var logic          rs1_eq_dst,
  input  var logic          rs2_eq_dst,
  input  var logic          br_cmp,
  input  var logic          br_jmp_reg,
  input  var logic          lsu_ex_sel,
  input  var logic          cp0_ex_sel,
  output logic              stall,
  output logic              stall_no_hready,
  output logic              branch_dep_ld
);

  logic in_load;
  logic in_ldst;
  logic load_use;
  logic clean_cmplt;

  assign in_load = (state == wb_pkg::st_load);
  assign in_ldst = in_load || (state == wb_pkg::st_store);

  //////////////////////////////////////////////////
  // Load-use hazard.
  //////////////////////////////////////////////////

  // Consumers that cannot take forwarded load data.
  assign load_use = in_load
                    && ((rs1_eq_dst && (br_jmp_reg || lsu_ex_sel || cp0_ex_sel))
                        || (br_cmp && (rs1_eq_dst || rs2_eq_dst)));

  assign clean_cmplt = lsu_cmplt && !lsu_acc_err && !lsu_chk_fail;

  //////////////////////////////////////////////////
  // Stall outputs.
  //////////////////////////////////////////////////

  assign stall           = load_use || (in_ldst && !clean_cmplt);
  assign stall_no_hready = load_use || (in_ldst && (lsu_acc_err || lsu_chk_fail));
  assign branch_dep_ld   = load_use || in_ldst;

endmodule

`default_nettype wire

// ==== rtl/wb_expt.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_expt #(
  parameter int unsigned DATA_W = wb_pkg::DATA_W_DFLT
) (
  input  wb_pkg::wb_state_e     state,
  input  var logic              lsu_cmplt,
  input  var logic              lsu_acc_err,
  input  var logic              lsu_chk_fail,
  input  var logic [DATA_W-1:0] wb_data_buf,
  input  var logic              special_sel,
  input  var logic [DATA_W-1:0] decd_tval,
  input  var logic              mem_bkpt_retire,
  input  var logic [DATA_W-1:0] lsu_addr,
  output logic                  acc_err_retire,
  output logic                  chk_fail_retire,
  output logic [DATA_W-1:0]     expt_tval
);

  logic in_ldst;

  assign in_ldst = (state == wb_pkg::st_load) || (state == wb_pkg::st_store);

  // Errors from an access that retired earlier.
  assign acc_err_retire  = in_ldst && lsu_cmplt && lsu_acc_err;
  assign chk_fail_retire = in_ldst && lsu_chk_fail;

  //////////////////////////////////////////////////
  // Trap value.
  //////////////////////////////////////////////////

  always_comb
  begin
    if (acc_err_retire)
      expt_tval = wb_data_buf; // Buffered faulting address.
    else if (special_sel)
      expt_tval = decd_tval;
    else if (mem_bkpt_retire)
      expt_tval = wb_data_buf;
    else
      expt_tval = lsu_addr;
  end

endmodule

`default_nettype wire

// ==== rtl/wb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_top #(
  parameter int unsigned DATA_W = wb_pkg::DATA_W_DFLT,
  parameter int unsigned IDX_W  = wb_pkg::IDX_W_DFLT
) (
  input  var logic              wb_clk,
  input  var logic              cpurst_b,
  // Execute strobes and result bus.
  input  var logic              alu_cmplt,
  input  var logic              load_issue,
  input  var logic              store_issue,
  input  var logic              inst_cmplt,
  input  var logic [DATA_W-1:0] rbus_data,
  input  var logic [IDX_W-1:0]  rbus_dst_idx,
  // Load/store unit.
  input  var logic              lsu_cmplt,
  input  var logic              lsu_data_vld,
  input  var logic [DATA_W-1:0] lsu_load_data,
  input  var logic              lsu_acc_err,
  input  var logic              lsu_chk_fail,
  input  var logic [DATA_W-1:0] lsu_addr,
  input  var logic              lsu_addr_vld,
  // Operand dependency info.
  input  var logic              rs1_eq_dst,
  input  var logic              rs2_eq_dst,
  input  var logic              br_cmp,
  input  var logic              br_jmp_reg,
  input  var logic              lsu_ex_sel,
  input  var logic              cp0_ex_sel,
  // Trap value sources.
  input  var logic              special_sel,
  input  var logic [DATA_W-1:0] decd_tval,
  input  var logic              mem_bkpt_retire,
  output logic                  st_aft_load,
  output logic                  store_uncmplt,
  output logic [4:0]            lsu_vec,
  output logic                  reg_we,
  output logic [IDX_W-1:0]      reg_idx,
  output logic [DATA_W-1:0]     reg_data,
  output logic                  fwd_en,
  output logic [DATA_W-1:0]     fwd_data,
  output logic                  stall,
  output logic                  stall_no_hready,
  output logic                  branch_dep_ld,
  output logic                  acc_err_retire,
  output logic                  chk_fail_retire,
  output logic [DATA_W-1:0]     expt_tval,
  output logic                  ldst_busy,
  output logic                  load_busy,
  output logic                  store_busy,
  output logic                  vector_wait
);

  wb_pkg::wb_state_e state;
  logic              ldst_wait;
  logic [DATA_W-1:0] wb_data_buf;

  //////////////////////////////////////////////////
  // Blocks.
  //////////////////////////////////////////////////

  wb_state_ctrl u_state_ctrl (
    .wb_clk        (wb_clk),
    .cpurst_b      (cpurst_b),
    .alu_cmplt     (alu_cmplt),
    .load_issue    (load_issue),
    .store_issue   (store_issue),
    .lsu_cmplt     (lsu_cmplt),
    .state         (state),
    .ldst_wait     (ldst_wait),
    .st_aft_load   (st_aft_load),
    .store_uncmplt (store_uncmplt),
    .lsu_vec       (lsu_vec)
  );

  wb_result_buf #(
    .DATA_W (DATA_W),
    .IDX_W  (IDX_W)
  ) u_result_buf (
    .wb_clk        (wb_clk),
    .cpurst_b      (cpurst_b),
    .state         (state),
    .alu_cmplt     (alu_cmplt),
    .load_issue    (load_issue),
    .inst_cmplt    (inst_cmplt),
    .rbus_data     (rbus_data),
    .rbus_dst_idx  (rbus_dst_idx),
    .lsu_addr      (lsu_addr),
    .lsu_addr_vld  (lsu_addr_vld),
    .lsu_cmplt     (lsu_cmplt),
    .lsu_data_vld  (lsu_data_vld),
    .lsu_load_data (lsu_load_data),
    .ldst_wait     (ldst_wait),
    .st_aft_load   (st_aft_load),
    .wb_data_buf   (wb_data_buf),
    .reg_we        (reg_we),
    .reg_idx       (reg_idx),
    .reg_data      (reg_data),
    .fwd_en        (fwd_en),
    .fwd_data      (fwd_data)
  );

  wb_hazard u_hazard (
    .state           (state),
    .lsu_cmplt       (lsu_cmplt),
    .lsu_acc_err     (lsu_acc_err),
    .lsu_chk_fail    (lsu_chk_fail),
    .rs1_eq_dst      (rs1_eq_dst),
    .rs2_eq_dst      (rs2_eq_dst),
    .br_cmp          (br_cmp),
    .br_jmp_reg      (br_jmp_reg),
    .lsu_ex_sel      (lsu_ex_sel),
    .cp0_ex_sel      (cp0_ex_sel),
    .stall           (stall),
    .stall_no_hready (stall_no_hready),
    .branch_dep_ld   (branch_dep_ld)
  );

  wb_expt #(
    .DATA_W (DATA_W)
  ) u_expt (
    .state           (state),
    .lsu_cmplt       (lsu_cmplt),
    .lsu_acc_err     (lsu_acc_err),
    .lsu_chk_fail    (lsu_chk_fail),
    .wb_data_buf     (wb_data_buf),
    .special_sel     (special_sel),
    .decd_tval       (decd_tval),
    .mem_bkpt_retire (mem_bkpt_retire),
    .lsu_addr        (lsu_addr),
    .acc_err_retire  (acc_err_retire),
    .chk_fail_retire (chk_fail_retire),
    .expt_tval       (expt_tval)
  );

  // Busy flags for fetch and the load/store unit.
  assign load_busy   = (state == wb_pkg::st_load);
  assign store_busy  = (state == wb_pkg::st_store);
  assign ldst_busy   = load_busy || store_busy;
  assign vector_wait = ldst_wait;

endmodule

`default_nettype wire

// ==== tests/wb_tb_model.svh ====
`ifndef WB_TB_MODEL_SVH
`define WB_TB_MODEL_SVH

//////////////////////////////////////////////////
// Reference model of the write-back stage.
//////////////////////////////////////////////////

function automatic logic sh_pending();
  return (sh_state == wb_pkg::st_load) || (sh_state == wb_pkg::st_store);
endfunction

function automatic logic dst_ok(input logic [4:0] idx);
  return (idx != 5'd0) && (idx < 5'd16); // Only 16 registers exist.
endfunction

function automatic wb_pkg::wb_state_e predict_next_state();
  if (sh_pending() && !lsu_cmplt)
    return sh_state;
  if (load_issue)
    return wb_pkg::st_load;
  if (store_issue)
    return wb_pkg::st_store;
  if (alu_cmplt)
    return wb_pkg::st_alu;
  return wb_pkg::st_idle;
endfunction

function automatic logic predict_reg_we();
  logic wr;
  wr = (sh_state == wb_pkg::st_alu)
       || ((sh_state == wb_pkg::st_load) && lsu_cmplt && lsu_data_vld);
  return wr && dst_ok(sh_idx);
endfunction

function automatic logic [31:0] predict_reg_data();
  return (sh_state == wb_pkg::st_load) ? lsu_load_data : sh_data;
endfunction

function automatic logic predict_acc_err();
  return sh_pending() && lsu_cmplt && lsu_acc_err;
endfunction

function automatic logic [31:0] predict_tval();
  if (predict_acc_err())
    return sh_data;
  if (special_sel)
    return decd_tval;
  if (mem_bkpt_retire)
    return sh_data;
  return lsu_addr;
endfunction

function automatic logic predict_load_use();
  return (sh_state == wb_pkg::st_load)
         && ((rs1_eq_dst && (br_jmp_reg || lsu_ex_sel || cp0_ex_sel))
             || (br_cmp && (rs1_eq_dst || rs2_eq_dst)));
endfunction

// Load leaving write-back.
function automatic logic predict_st_aft_load();
  return (sh_state == wb_pkg::st_load)
         && (store_issue || (predict_next_state() == wb_pkg::st_idle));
endfunction

function automatic logic [31:0] predict_data_buf();
  logic upd;
  upd = alu_cmplt || inst_cmplt || predict_st_aft_load()
        || (lsu_addr_vld && !(sh_pending() && !lsu_cmplt));
  if (!upd)
    return sh_data;
  return lsu_addr_vld ? lsu_addr : rbus_data;
endfunction

`endif

// ==== tests/wb_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_tb;

  localparam int N_TXN   = 400;
  localparam int RST_CYC = 10;

  logic wb_clk, cpurst_b;
  logic alu_cmplt, load_issue, store_issue, inst_cmplt;
  logic [31:0] rbus_data, lsu_load_data, lsu_addr, decd_tval;
  logic [4:0] rbus_dst_idx;
  logic lsu_cmplt, lsu_data_vld, lsu_acc_err, lsu_chk_fail, lsu_addr_vld;
  logic rs1_eq_dst, rs2_eq_dst, br_cmp, br_jmp_reg, lsu_ex_sel, cp0_ex_sel;
  logic special_sel, mem_bkpt_retire;
  logic st_aft_load, store_uncmplt, reg_we, fwd_en, stall, stall_no_hready;
  logic branch_dep_ld, acc_err_retire, chk_fail_retire;
  logic ldst_busy, load_busy, store_busy, vector_wait;
  logic [4:0] lsu_vec, reg_idx;
  logic [31:0] reg_data, fwd_data, expt_tval;

  wb_pkg::wb_state_e sh_state = wb_pkg::st_idle;
  logic [4:0]  sh_idx  = '0;
  logic [31:0] sh_data = '0;
  int err_cnt = 0;
  int chk_cnt = 0;
  int strobes = 0;

  `include "wb_tb_model.svh"

  wb_top wb_top_i (.*);

  initial
  begin
    wb_clk = 1'b0;
    forever #2 wb_clk = ~wb_clk;
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    assert (got === exp)
    else
    begin
      err_cnt++;
      $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    chk_cnt++;
    assert (got === exp)
    else
    begin
      err_cnt++;
      $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus.
  //////////////////////////////////////////////////

  task automatic drive_cycle();
    logic cmplt;
    logic strobe;
    int kind;
    cmplt  = ($urandom % 3) == 0;
    strobe = !(sh_pending() && !cmplt) && ($urandom % 2); // No strobe while an access waits.
    kind   = $urandom % 3;
    alu_cmplt       <= strobe && (kind == 0);
    load_issue      <= strobe && (kind == 1);
    store_issue     <= strobe && (kind == 2);
    inst_cmplt      <= ($urandom % 4) == 0;
    rbus_data       <= $urandom;
    rbus_dst_idx    <= 5'($urandom);
    lsu_cmplt       <= cmplt;
    lsu_data_vld    <= 1'($urandom % 2);
    lsu_load_data   <= $urandom;
    lsu_acc_err     <= ($urandom % 6) == 0;
    lsu_chk_fail    <= ($urandom % 6) == 0;
    lsu_addr        <= $urandom;
    lsu_addr_vld    <= 1'($urandom % 2);
    {rs1_eq_dst, rs2_eq_dst, br_cmp} <= 3'($urandom);
    {br_jmp_reg, lsu_ex_sel, cp0_ex_sel} <= 3'($urandom);
    special_sel     <= ($urandom % 4) == 0;
    mem_bkpt_retire <= ($urandom % 4) == 0;
    decd_tval       <= $urandom;
    if (strobe)
      strobes++;
  endtask

  initial
  begin
    void'($urandom(32'h4a9e68f5));
    cpurst_b = 1'b0;
    {alu_cmplt, load_issue, store_issue, inst_cmplt} = '0;
    {rbus_data, rbus_dst_idx, lsu_load_data, lsu_addr, decd_tval} = '0;
    {lsu_cmplt, lsu_data_vld, lsu_acc_err, lsu_chk_fail, lsu_addr_vld} = '0;
    {rs1_eq_dst, rs2_eq_dst, br_cmp, br_jmp_reg, lsu_ex_sel, cp0_ex_sel} = '0;
    {special_sel, mem_bkpt_retire} = '0;
    repeat (RST_CYC) @(posedge wb_clk);
    cpurst_b <= 1'b1; // Strobes stay low in the release cycle.
    repeat (3) @(posedge wb_clk);
    while (strobes < N_TXN)
    begin
      @(posedge wb_clk);
      drive_cycle();
    end
    @(posedge wb_clk);
    alu_cmplt   <= 1'b0;
    load_issue  <= 1'b0;
    store_issue <= 1'b0;
    repeat (5) @(posedge wb_clk);
    $display("Checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  //////////////////////////////////////////////////
  // Compare against the model on the falling edge.
  //////////////////////////////////////////////////

  always @(negedge wb_clk)
  begin
    wb_pkg::wb_state_e n_state;
    logic [31:0] n_data;
    logic lu;
    logic [4:0] exp_vec;
    lu = predict_load_use();
    exp_vec = (sh_state == wb_pkg::st_load) ? wb_pkg::LSU_VEC_LOAD : wb_pkg::LSU_VEC_OTHER;
    check_bit("load_busy", load_busy, sh_state == wb_pkg::st_load);
    check_bit("store_busy", store_busy, sh_state == wb_pkg::st_store);
    check_bit("ldst_busy", ldst_busy, sh_pending());
    check_bit("reg_we", reg_we, predict_reg_we());
    if (predict_reg_we())
    begin
      check_val("reg_idx", 32'(reg_idx), 32'(sh_idx));
      check_val("reg_data", reg_data, predict_reg_data());
    end
    check_bit("fwd_en", fwd_en,
              ((sh_state == wb_pkg::st_alu) || (sh_state == wb_pkg::st_load)) && dst_ok(sh_idx));
    if (fwd_en)
      check_val("fwd_data", fwd_data, sh_data);
    check_bit("vector_wait", vector_wait, sh_pending() && !lsu_cmplt);
    check_bit("store_uncmplt", store_uncmplt, (sh_state == wb_pkg::st_store) && !lsu_cmplt);
    check_bit("st_aft_load", st_aft_load, predict_st_aft_load());
    check_val("lsu_vec", 32'(lsu_vec), 32'(exp_vec));
    check_bit("acc_err_retire", acc_err_retire, predict_acc_err());
    check_bit("chk_fail_retire", chk_fail_retire, sh_pending() && lsu_chk_fail);
    check_val("expt_tval", expt_tval, predict_tval());
    check_bit("stall", stall,
              lu || (sh_pending() && !(lsu_cmplt && !lsu_acc_err && !lsu_chk_fail)));
    check_bit("stall_no_hready", stall_no_hready,
              lu || (sh_pending() && (lsu_acc_err || lsu_chk_fail)));
    check_bit("branch_dep_ld", branch_dep_ld, lu || sh_pending());
    // Shadow state for the cycle after the next rising edge.
    if (!cpurst_b)
    begin
      sh_state = wb_pkg::st_idle;
      sh_idx   = '0;
      sh_data  = '0;
    end
    else
    begin
      n_state = predict_next_state();
      n_data  = predict_data_buf();
      if (alu_cmplt || load_issue)
        sh_idx = rbus_dst_idx;
      sh_data  = n_data;
      sh_state = n_state;
    end
  end

  // Watchdog.
  initial
  begin
    repeat (N_TXN * 20 + RST_CYC) @(posedge wb_clk);
    $display("Timeout: the run did not finish in time");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+tests
rtl/wb_pkg.sv
rtl/wb_state_ctrl.sv
rtl/wb_result_buf.sv
rtl/wb_hazard.sv
rtl/wb_expt.sv
rtl/wb_top.sv
tests/wb_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the write-back stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module wb_tb -f list.f -o wb_sim
if [ $? -ne 0 ]; then
  echo "Compile failed"
  exit 1
fi

./obj_dir/wb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation returned status $status"
  exit 1
fi

if grep -q "^NO ERRORS$" sim.log; then
  exit 0
fi
exit 1
